//--- src/axi4_write_cfg.svh
`ifndef AXI4_WRITE_CFG_SVH
`define AXI4_WRITE_CFG_SVH

// AXI4 bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_SIZE 2
`define AXI_DATA_WIDTH 32
`define AXI_LEN_WIDTH 8

// request beat count field
`define REQ_SIZE_WIDTH 10

// 2^12 = 4 KB burst boundary
`define AXI_ALIGN 12

// queue depths as log2
`define WFIFO_PTR_WIDTH 6
`define CMDQ_PTR_WIDTH 3

`endif

//--- src/axi4_write_pkg.sv
`include "axi4_write_cfg.svh"

package axi4_write_pkg;

    // byte address and one data beat
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;

    // lengths are stored minus one
    typedef logic [`AXI_LEN_WIDTH-1:0] len_t;
    typedef logic [`REQ_SIZE_WIDTH-1:0] size_t;

    // beats held in the write data FIFO
    typedef logic [`WFIFO_PTR_WIDTH:0] cap_t;

endpackage

//--- src/burst_cmd_if.sv
`timescale 1ns/1ps

interface burst_cmd_if;
    import axi4_write_pkg::*;

    addr_t addr;
    len_t  len;
    logic  last;
    logic  valid;
    logic  ready;

    modport src (output addr, output len, output last, output valid, input ready);
    modport dst (input addr, input len, input last, input valid, output ready);

endinterface

//--- src/burst_splitter.sv
`timescale 1ns/1ps
`include "axi4_write_cfg.svh"

module burst_splitter (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    input  axi4_write_pkg::addr_t i_awaddr,
    input  axi4_write_pkg::size_t i_awlen,
    input  axi4_write_pkg::len_t  i_awlen_max,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    burst_cmd_if.src              cmd
);
    import axi4_write_pkg::*;

    localparam int PAGE_BITS = `AXI_ALIGN - `AXI_DATA_SIZE;

    addr_t                cur_addr;
    size_t                rem_m1;
    len_t                 max_m1;
    logic                 busy;
    logic                 accept;
    logic                 take;
    logic [PAGE_BITS-1:0] page_left_m1;
    size_t                step_m1;

    assign o_awready = !busy;
    assign accept    = i_awvalid && !busy;
    assign take      = cmd.valid && cmd.ready;

    // ------------------------------
    // burst size
    // ------------------------------

    // beats up to the 4 KB edge, minus one
    assign page_left_m1 = ~cur_addr[`AXI_ALIGN-1:`AXI_DATA_SIZE];

    always_comb begin
        step_m1 = size_t'(max_m1);
        if (rem_m1 < step_m1) begin
            step_m1 = rem_m1;
        end
        if (size_t'(page_left_m1) < step_m1) begin
            step_m1 = size_t'(page_left_m1);
        end
    end

    assign cmd.addr  = cur_addr;
    assign cmd.len   = len_t'(step_m1);
    assign cmd.last  = (step_m1 == rem_m1);
    assign cmd.valid = busy;

    // ------------------------------
    // request state
    // ------------------------------

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (take && cmd.last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (accept) begin
            // beat aligned start
            cur_addr <= {i_awaddr[`AXI_ADDR_WIDTH-1:`AXI_DATA_SIZE], {`AXI_DATA_SIZE{1'b0}}};
            rem_m1   <= i_awlen;
            max_m1   <= i_awlen_max;
        end else if (take) begin
            cur_addr <= cur_addr + ((addr_t'(step_m1) + addr_t'(1)) << `AXI_DATA_SIZE);
            rem_m1   <= rem_m1 - step_m1 - size_t'(1);
        end
    end

endmodule

//--- src/wdata_fifo.sv
`timescale 1ns/1ps
`include "axi4_write_cfg.svh"

module wdata_fifo (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    input  axi4_write_pkg::data_t i_wdata,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic                  o_push,
    output axi4_write_pkg::data_t o_data,
    output logic                  o_valid,
    input  logic                  i_ready
);
    import axi4_write_pkg::*;

    localparam int PW    = `WFIFO_PTR_WIDTH;
    localparam int DEPTH = 1 << PW;

    data_t       mem [DEPTH];
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        full;
    logic        pop;

    // pointers carry one wrap bit
    assign full     = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
    assign o_wready = !full;
    assign o_push   = i_wvalid && !full;

    // first word falls through
    assign o_valid = (wr_ptr != rd_ptr);
    assign o_data  = mem[rd_ptr[PW-1:0]];
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (o_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (o_push) begin
            mem[wr_ptr[PW-1:0]] <= i_wdata;
        end
    end

endmodule

//--- src/burst_issue.sv
`timescale 1ns/1ps

module burst_issue (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    burst_cmd_if.dst              cmd,
    input  logic                  i_push,
    output axi4_write_pkg::addr_t o_m_axi4_awaddr,
    output axi4_write_pkg::len_t  o_m_axi4_awlen,
    output logic                  o_m_axi4_awvalid,
    input  logic                  i_m_axi4_awready,
    output axi4_write_pkg::len_t  o_len,
    output logic                  o_len_valid,
    input  logic                  i_len_ready,
    output logic                  o_last,
    output logic                  o_last_valid,
    input  logic                  i_last_ready
);
    import axi4_write_pkg::*;

    cap_t cap;
    cap_t claim;
    logic cap_ok;
    logic aw_free;
    logic accept;

    // ------------------------------
    // capacity gate
    // ------------------------------

    // need len + 1 unclaimed beats
    assign cap_ok  = int'(cap) > int'(cmd.len);
    assign aw_free = !o_m_axi4_awvalid || i_m_axi4_awready;

    assign cmd.ready = aw_free && cap_ok && i_len_ready && i_last_ready;
    assign accept    = cmd.valid && cmd.ready;
    assign claim     = accept ? cap_t'(cmd.len) + cap_t'(1) : cap_t'(0);

    // len and last fork to both queues in the same cycle
    assign o_len        = cmd.len;
    assign o_len_valid  = cmd.valid && aw_free && cap_ok && i_last_ready;
    assign o_last       = cmd.last;
    assign o_last_valid = cmd.valid && aw_free && cap_ok && i_len_ready;

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            cap              <= '0;
            o_m_axi4_awvalid <= 1'b0;
        end else begin
            cap <= cap + cap_t'(i_push) - claim;
            if (accept) begin
                o_m_axi4_awvalid <= 1'b1;
            end else if (i_m_axi4_awready) begin
                o_m_axi4_awvalid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // AW channel
    // ------------------------------

    always_ff @(posedge i_aclk) begin
        if (accept) begin
            o_m_axi4_awaddr <= cmd.addr;
            o_m_axi4_awlen  <= cmd.len;
        end
    end

endmodule

//--- src/wdata_gate.sv
`timescale 1ns/1ps
`include "axi4_write_cfg.svh"

module wdata_gate (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    input  axi4_write_pkg::len_t  i_len,
    input  logic                  i_len_valid,
    output logic                  o_len_ready,
    input  axi4_write_pkg::data_t i_data,
    input  logic                  i_valid,
    output logic                  o_ready,
    output axi4_write_pkg::data_t o_m_axi4_wdata,
    output logic                  o_m_axi4_wlast,
    output logic                  o_m_axi4_wvalid,
    input  logic                  i_m_axi4_wready
);
    import axi4_write_pkg::*;

    localparam int PW    = `CMDQ_PTR_WIDTH;
    localparam int DEPTH = 1 << PW;

    len_t        len_q [DEPTH];
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        q_valid;
    len_t        beat;
    logic        beat_done;

    assign o_len_ready = !((wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]));
    assign q_valid     = (wr_ptr != rd_ptr);

    // beats only pass while a burst length is queued
    assign o_m_axi4_wdata  = i_data;
    assign o_m_axi4_wvalid = q_valid && i_valid;
    assign o_m_axi4_wlast  = (beat == len_q[rd_ptr[PW-1:0]]);
    assign o_ready         = q_valid && i_m_axi4_wready;
    assign beat_done       = o_m_axi4_wvalid && i_m_axi4_wready;

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            beat   <= '0;
        end else begin
            if (i_len_valid && o_len_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (beat_done && o_m_axi4_wlast) begin
                rd_ptr <= rd_ptr + 1'b1;
                beat   <= '0;
            end else if (beat_done) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_len_valid && o_len_ready) begin
            len_q[wr_ptr[PW-1:0]] <= i_len;
        end
    end

endmodule

//--- src/write_ack.sv
`timescale 1ns/1ps
`include "axi4_write_cfg.svh"

module write_ack (
    input  logic i_aclk,
    input  logic i_reset,
    input  logic i_last,
    input  logic i_last_valid,
    output logic o_last_ready,
    input  logic i_m_axi4_bvalid,
    output logic o_m_axi4_bready,
    output logic o_bvalid,
    input  logic i_bready
);
    import axi4_write_pkg::*;

    localparam int PW    = `CMDQ_PTR_WIDTH;
    localparam int DEPTH = 1 << PW;

    logic [DEPTH-1:0] tag_q;
    logic [PW:0]      wr_ptr;
    logic [PW:0]      rd_ptr;
    cap_t             done_cnt;
    logic             b_take;
    logic             tag_done;
    logic             b_ack;

    assign o_last_ready    = !((wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]));
    assign o_m_axi4_bready = (wr_ptr != rd_ptr);

    // one tag per B response, set on a request's final burst
    assign b_take   = i_m_axi4_bvalid && o_m_axi4_bready;
    assign tag_done = b_take && tag_q[rd_ptr[PW-1:0]];
    assign o_bvalid = (done_cnt != '0);
    assign b_ack    = o_bvalid && i_bready;

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            done_cnt <= '0;
        end else begin
            if (i_last_valid && o_last_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (b_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            done_cnt <= done_cnt + cap_t'(tag_done) - cap_t'(b_ack);
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_last_valid && o_last_ready) begin
            tag_q[wr_ptr[PW-1:0]] <= i_last;
        end
    end

endmodule

//--- src/axi4_write.sv
`timescale 1ns/1ps

module axi4_write (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    input  axi4_write_pkg::addr_t i_awaddr,
    input  axi4_write_pkg::size_t i_awlen,
    input  axi4_write_pkg::len_t  i_awlen_max,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  axi4_write_pkg::data_t i_wdata,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    output axi4_write_pkg::addr_t o_m_axi4_awaddr,
    output axi4_write_pkg::len_t  o_m_axi4_awlen,
    output logic                  o_m_axi4_awvalid,
    input  logic                  i_m_axi4_awready,
    output axi4_write_pkg::data_t o_m_axi4_wdata,
    output logic                  o_m_axi4_wlast,
    output logic                  o_m_axi4_wvalid,
    input  logic                  i_m_axi4_wready,
    input  logic [1:0]            i_m_axi4_bresp,
    input  logic                  i_m_axi4_bvalid,
    output logic                  o_m_axi4_bready
);
    import axi4_write_pkg::*;

    burst_cmd_if cmd_bus ();

    logic  push;
    data_t fifo_data;
    logic  fifo_valid;
    logic  fifo_ready;
    len_t  len;
    logic  len_valid;
    logic  len_ready;
    logic  last;
    logic  last_valid;
    logic  last_ready;

    // ------------------------------
    // command path
    // ------------------------------

    burst_splitter u_splitter (
        .i_aclk      (i_aclk),
        .i_reset     (i_reset),
        .i_awaddr    (i_awaddr),
        .i_awlen     (i_awlen),
        .i_awlen_max (i_awlen_max),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .cmd         (cmd_bus.src)
    );

    burst_issue u_issue (
        .i_aclk           (i_aclk),
        .i_reset          (i_reset),
        .cmd              (cmd_bus.dst),
        .i_push           (push),
        .o_m_axi4_awaddr  (o_m_axi4_awaddr),
        .o_m_axi4_awlen   (o_m_axi4_awlen),
        .o_m_axi4_awvalid (o_m_axi4_awvalid),
        .i_m_axi4_awready (i_m_axi4_awready),
        .o_len            (len),
        .o_len_valid      (len_valid),
        .i_len_ready      (len_ready),
        .o_last           (last),
        .o_last_valid     (last_valid),
        .i_last_ready     (last_ready)
    );

    // ------------------------------
    // data and response path
    // ------------------------------

    wdata_fifo u_fifo (
        .i_aclk   (i_aclk),
        .i_reset  (i_reset),
        .i_wdata  (i_wdata),
        .i_wvalid (i_wvalid),
        .o_wready (o_wready),
        .o_push   (push),
        .o_data   (fifo_data),
        .o_valid  (fifo_valid),
        .i_ready  (fifo_ready)
    );

    wdata_gate u_gate (
        .i_aclk          (i_aclk),
        .i_reset         (i_reset),
        .i_len           (len),
        .i_len_valid     (len_valid),
        .o_len_ready     (len_ready),
        .i_data          (fifo_data),
        .i_valid         (fifo_valid),
        .o_ready         (fifo_ready),
        .o_m_axi4_wdata  (o_m_axi4_wdata),
        .o_m_axi4_wlast  (o_m_axi4_wlast),
        .o_m_axi4_wvalid (o_m_axi4_wvalid),
        .i_m_axi4_wready (i_m_axi4_wready)
    );

    // bresp is not checked
    write_ack u_ack (
        .i_aclk          (i_aclk),
        .i_reset         (i_reset),
        .i_last          (last),
        .i_last_valid    (last_valid),
        .o_last_ready    (last_ready),
        .i_m_axi4_bvalid (i_m_axi4_bvalid),
        .o_m_axi4_bready (o_m_axi4_bready),
        .o_bvalid        (o_bvalid),
        .i_bready        (i_bready)
    );

endmodule

//--- tests/axi4_slave_model.sv
`timescale 1ns/1ps

module axi4_slave_model #(
    parameter logic [31:0] SEED = 32'h8657
) (
    input  logic       i_aclk,
    input  logic       i_reset,
    input  logic       i_awvalid,
    output logic       o_awready,
    input  logic       i_wvalid,
    input  logic       i_wlast,
    output logic       o_wready,
    output logic       o_bvalid,
    output logic [1:0] o_bresp,
    input  logic       i_bready
);

    logic [31:0] rng_state = SEED;
    int          aw_cnt;
    int          wlast_cnt;
    int          b_cnt;
    int          ready_bursts;
    logic        b_take;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    initial begin
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        o_bresp   = 2'b00;
        b_take    = 1'b0;
        forever begin
            @(posedge i_aclk);
            if (i_reset) begin
                aw_cnt    = 0;
                wlast_cnt = 0;
                b_cnt     = 0;
                b_take    = 1'b0;
            end else begin
                if (i_awvalid && o_awready) begin
                    aw_cnt++;
                end
                if (i_wvalid && o_wready && i_wlast) begin
                    wlast_cnt++;
                end
                b_take = o_bvalid && i_bready;
                if (b_take) begin
                    b_cnt++;
                end
            end
            #1;
            o_awready = (next_rand() % 4) != 0;
            o_wready  = (next_rand() % 5) != 0;
            // a response needs both the address and the last beat
            ready_bursts = (aw_cnt < wlast_cnt) ? aw_cnt : wlast_cnt;
            if (!o_bvalid || b_take) begin
                o_bvalid = (ready_bursts > b_cnt) && ((next_rand() % 3) != 0);
            end
        end
    end

endmodule

//--- tests/tb_axi4_write.sv
`timescale 1ns/1ps
`include "axi4_write_cfg.svh"

module tb_axi4_write;
    import axi4_write_pkg::*;

    localparam int N_REQ          = 20;
    localparam int MAX_BEATS      = 160;
    localparam int PAGE           = 1 << `AXI_ALIGN;
    localparam int BEAT_BYTES     = 1 << `AXI_DATA_SIZE;
    // about six cycles per beat under the heaviest stalls
    localparam int TIMEOUT_CYCLES = N_REQ * MAX_BEATS * 6 + 800;

    logic       i_aclk;
    logic       i_reset;
    addr_t      i_awaddr;
    size_t      i_awlen;
    len_t       i_awlen_max;
    logic       i_awvalid;
    logic       o_awready;
    data_t      i_wdata;
    logic       i_wvalid;
    logic       o_wready;
    logic       o_bvalid;
    logic       i_bready;
    addr_t      o_m_axi4_awaddr;
    len_t       o_m_axi4_awlen;
    logic       o_m_axi4_awvalid;
    logic       i_m_axi4_awready;
    data_t      o_m_axi4_wdata;
    logic       o_m_axi4_wlast;
    logic       o_m_axi4_wvalid;
    logic       i_m_axi4_wready;
    logic [1:0] i_m_axi4_bresp;
    logic       i_m_axi4_bvalid;
    logic       o_m_axi4_bready;

    logic [31:0] rng_state = 32'h8657;
    addr_t       req_addr [N_REQ];
    size_t       req_len [N_REQ];
    len_t        req_max [N_REQ];
    addr_t       exp_addr [$];
    len_t        exp_len [$];
    logic        exp_last [$];
    logic        want_last;
    int          total_beats;
    int          errors;
    int          cycles;
    int          aw_idx;
    int          w_idx;
    int          w_beat;
    int          w_total;
    int          b_idx;
    int          b_reqs;
    int          b_done;
    int          beats_in;
    int          beats_issued;

    axi4_write dut0 (.*);

    axi4_slave_model slave (
        .i_aclk    (i_aclk),
        .i_reset   (i_reset),
        .i_awvalid (o_m_axi4_awvalid),
        .o_awready (i_m_axi4_awready),
        .i_wvalid  (o_m_axi4_wvalid),
        .i_wlast   (o_m_axi4_wlast),
        .o_wready  (i_m_axi4_wready),
        .o_bvalid  (i_m_axi4_bvalid),
        .o_bresp   (i_m_axi4_bresp),
        .i_bready  (o_m_axi4_bready)
    );

    initial begin
        i_aclk = 1'b0;
        forever #50 i_aclk = ~i_aclk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    function automatic data_t beat_value(input int idx);
        return data_t'(idx) * 32'h0001_0003 ^ 32'h5a00_0000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("error t=%0t %s: got %h expected %h", $time, name, got, want);
    endtask

    task automatic report_counts();
        $display("errors %0d, bursts %0d of %0d, beats %0d of %0d, completions %0d of %0d",
                 errors, aw_idx, exp_addr.size(), w_total, total_beats, b_done, N_REQ);
    endtask

    // ------------------------------
    // reference bursts
    // ------------------------------

    task automatic split_request(input addr_t a, input int beats, input int max_beats);
        int edge_beats;
        int n;
        while (beats > 0) begin
            edge_beats = (PAGE - int'(a[`AXI_ALIGN-1:0])) / BEAT_BYTES;
            n = beats;
            if (max_beats < n) begin
                n = max_beats;
            end
            if (edge_beats < n) begin
                n = edge_beats;
            end
            exp_addr.push_back(a);
            exp_len.push_back(len_t'(n - 1));
            exp_last.push_back(n == beats);
            a = a + addr_t'(n * BEAT_BYTES);
            beats -= n;
        end
    endtask

    task automatic build_requests();
        logic [31:0] page_r;
        logic [31:0] off_r;
        logic [31:0] max_r;
        for (int k = 0; k < N_REQ; k++) begin
            page_r = next_rand();
            off_r  = next_rand();
            max_r  = next_rand();
            // start a little below a 4 KB edge
            req_addr[k] = addr_t'(page_r << `AXI_ALIGN) - addr_t'((off_r % 300) * BEAT_BYTES);
            req_len[k]  = size_t'(next_rand() % MAX_BEATS);
            // bursts of up to 64 beats fit the data FIFO
            req_max[k]  = (max_r % 4 == 0) ? len_t'(63) : len_t'(max_r % 24);
            split_request(req_addr[k], int'(req_len[k]) + 1, int'(req_max[k]) + 1);
            total_beats += int'(req_len[k]) + 1;
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic drive_requests();
        int gap;
        for (int k = 0; k < N_REQ; k++) begin
            i_awaddr    = req_addr[k];
            i_awlen     = req_len[k];
            i_awlen_max = req_max[k];
            i_awvalid   = 1'b1;
            @(posedge i_aclk);
            while (!o_awready) begin
                @(posedge i_aclk);
            end
            #1;
            i_awvalid = 1'b0;
            gap = next_rand() % 4;
            repeat (gap) begin
                @(posedge i_aclk);
                #1;
            end
        end
    endtask

    task automatic drive_data();
        int   sent;
        logic took;
        sent = 0;
        while (sent < total_beats) begin
            @(posedge i_aclk);
            took = i_wvalid && o_wready;
            if (took) begin
                sent++;
            end
            #1;
            if (sent == total_beats) begin
                i_wvalid = 1'b0;
            end else if (!i_wvalid || took) begin
                i_wdata  = beat_value(sent);
                i_wvalid = (next_rand() % 4) != 0;
            end
        end
    endtask

    task automatic drive_bready();
        forever begin
            @(posedge i_aclk);
            #1;
            i_bready = (next_rand() % 3) != 0;
        end
    endtask

    // ------------------------------
    // checks
    // ------------------------------

    always @(posedge i_aclk) begin
        if (!i_reset) begin
            if (o_m_axi4_awvalid && i_m_axi4_awready) begin
                beats_issued += int'(o_m_axi4_awlen) + 1;
                assert (aw_idx < exp_addr.size()) else begin
                    errors++;
                    $display("burst at %h issued after all expected bursts", o_m_axi4_awaddr);
                end
                if (aw_idx < exp_addr.size()) begin
                    assert (o_m_axi4_awaddr == exp_addr[aw_idx])
                        else report_mismatch("awaddr", o_m_axi4_awaddr, exp_addr[aw_idx]);
                    assert (o_m_axi4_awlen == exp_len[aw_idx])
                        else report_mismatch("awlen", o_m_axi4_awlen, exp_len[aw_idx]);
                end
                assert (int'(o_m_axi4_awaddr[`AXI_ALIGN-1:0])
                        + (int'(o_m_axi4_awlen) + 1) * BEAT_BYTES <= PAGE) else begin
                    errors++;
                    $display("burst at %h with %0d beats crosses a 4 KB boundary",
                             o_m_axi4_awaddr, int'(o_m_axi4_awlen) + 1);
                end
                assert (beats_in >= beats_issued) else begin
                    errors++;
                    $display("burst at %h issued with only %0d of %0d beats buffered",
                             o_m_axi4_awaddr, beats_in, beats_issued);
                end
                aw_idx++;
            end
            if (o_m_axi4_wvalid && i_m_axi4_wready) begin
                assert (o_m_axi4_wdata == beat_value(w_total))
                    else report_mismatch("wdata", o_m_axi4_wdata, beat_value(w_total));
                if (w_idx < exp_len.size()) begin
                    want_last = (w_beat == int'(exp_len[w_idx]));
                    assert (o_m_axi4_wlast == want_last)
                        else report_mismatch("wlast", {31'b0, o_m_axi4_wlast}, {31'b0, want_last});
                    if (want_last) begin
                        w_idx++;
                        w_beat = 0;
                    end else begin
                        w_beat++;
                    end
                end else begin
                    errors++;
                    $display("write beat %0d sent after all expected bursts", w_total);
                end
                w_total++;
            end
            if (o_bvalid && i_bready) begin
                b_done++;
                assert (b_done <= b_reqs) else begin
                    errors++;
                    $display("completion %0d reported before its last B response", b_done);
                end
            end
            if (i_m_axi4_bvalid && o_m_axi4_bready) begin
                if (b_idx < exp_last.size() && exp_last[b_idx]) begin
                    b_reqs++;
                end
                b_idx++;
            end
            if (i_wvalid && o_wready) begin
                beats_in++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_aclk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d completions", cycles, b_done, N_REQ);
        report_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        i_reset     = 1'b1;
        i_awaddr    = '0;
        i_awlen     = '0;
        i_awlen_max = '0;
        i_awvalid   = 1'b0;
        i_wdata     = '0;
        i_wvalid    = 1'b0;
        i_bready    = 1'b0;
        build_requests();
        repeat (2) @(posedge i_aclk);
        #1;
        i_reset = 1'b0;
        fork
            drive_requests();
            drive_data();
            drive_bready();
        join_none
        wait (b_done == N_REQ);
        // let a duplicate completion show up
        repeat (20) @(posedge i_aclk);
        assert (aw_idx == exp_addr.size()) else begin
            errors++;
            $display("%0d bursts issued, %0d expected", aw_idx, exp_addr.size());
        end
        assert (w_total == total_beats) else begin
            errors++;
            $display("%0d write beats sent, %0d expected", w_total, total_beats);
        end
        assert (b_done == N_REQ) else begin
            errors++;
            $display("%0d completions reported for %0d requests", b_done, N_REQ);
        end
        report_counts();
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/axi4_write_pkg.sv
src/burst_cmd_if.sv
src/burst_splitter.sv
src/wdata_fifo.sv
src/burst_issue.sv
src/wdata_gate.sv
src/write_ack.sv
src/axi4_write.sv
tests/axi4_slave_model.sv
tests/tb_axi4_write.sv
